//--- iq_pkg.sv
// ------------------------------------------------
// issue queue sizes, alu function codes, and the
// instruction, dispatch lane and issue pair structs
// ------------------------------------------------

package iq_pkg;

  // queue geometry
  localparam int IQ_DEPTH = 32;
  localparam int IQ_PTR_W = 5;
  localparam int IQ_LANES = 2;

  // core widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ROB_SLOT_W = 5;
  localparam int ROB_DEPTH  = 1 << ROB_SLOT_W;

  typedef logic [IQ_PTR_W-1:0] iq_slot_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_COPY = 4'd10
  } alu_fn_e;

  // one decoded instruction as held in the queue
  typedef struct packed {
    logic [XLEN-1:0]       ir;
    logic                  rf_wen;
    logic [REG_ADDR_W-1:0] rf_waddr;
    alu_fn_e               alu_fn;
    logic                  jump;
    logic [ROB_SLOT_W-1:0] rob_slot;
    logic [REG_ADDR_W-1:0] rs0_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
  } iq_inst_t;

  // spec means issued behind a branch still in flight
  typedef struct packed {
    logic     val;
    logic     spec;
    iq_inst_t inst;
  } iq_lane_t;

  // slot0 is the older entry of the pair
  typedef struct packed {
    iq_slot_t slot0;
    iq_slot_t slot1;
    iq_inst_t inst0;
    iq_inst_t inst1;
  } iq_issue_t;

endpackage

//--- iq_dispatch.sv
// ------------------------------------------------
// dispatch side, lane compaction, tail pointer
// and enqueue ready
// ------------------------------------------------

`timescale 1ns/1ns

module iq_dispatch import iq_pkg::*; (
  input  logic                clk,
  input  logic                reset,

  input  iq_lane_t            lane0,
  input  iq_lane_t            lane1,
  output logic                enq_rdy,

  input  iq_slot_t            head,
  input  logic [IQ_PTR_W:0]   occupied,
  output iq_slot_t            tail,

  output logic                wr_en0,
  output logic                wr_en1,
  output iq_slot_t            wr_slot0,
  output iq_slot_t            wr_slot1,
  output iq_lane_t            wr_lane0,
  output iq_lane_t            wr_lane1
);

  iq_slot_t tail_q;
  iq_slot_t gap;
  logic     empty;

  assign tail = tail_q;

  // ------------------------------------------------
  // enqueue ready
  // ------------------------------------------------

  // distance from tail forward to head, zero when empty
  assign gap   = head - tail_q;
  assign empty = (occupied == '0);

  // one slot always stays open so head == tail means empty
  assign enq_rdy = empty || (gap > iq_slot_t'(IQ_LANES));

  // ------------------------------------------------
  // lane compaction
  // ------------------------------------------------

  // a lone lane goes to the tail whichever lane it came on
  assign wr_en0   = enq_rdy && (lane0.val || lane1.val);
  assign wr_en1   = enq_rdy && lane0.val && lane1.val;
  assign wr_lane0 = lane0.val ? lane0 : lane1;
  assign wr_lane1 = lane1;
  assign wr_slot0 = tail_q;
  assign wr_slot1 = tail_q + iq_slot_t'(1);

  // tail moves by the number of lanes taken
  always_ff @(posedge clk) begin
    if (reset) begin
      tail_q <= '0;
    end else begin
      tail_q <= tail_q + iq_slot_t'(wr_en0) + iq_slot_t'(wr_en1);
    end
  end

endmodule

//--- iq_entry_buffer.sv
// ------------------------------------------------
// entry storage with valid and spec bits, head
// advance, branch flush and jump indication
// ------------------------------------------------

`timescale 1ns/1ns

module iq_entry_buffer import iq_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,

  // writes from dispatch
  input  logic                          wr_en0,
  input  logic                          wr_en1,
  input  iq_slot_t                      wr_slot0,
  input  iq_slot_t                      wr_slot1,
  input  iq_lane_t                      wr_lane0,
  input  iq_lane_t                      wr_lane1,
  input  iq_slot_t                      tail,

  // frees from issue select
  input  logic                          issue_fire,
  input  iq_slot_t                      issue_slot0,
  input  iq_slot_t                      issue_slot1,

  input  logic                          br_resolved,
  input  logic                          br_taken,

  output iq_slot_t                      head,
  output logic [IQ_PTR_W:0]             occupied,
  output logic [IQ_DEPTH-1:0]           live,
  output iq_inst_t [IQ_DEPTH-1:0]       entries,
  output logic                          contains_jump
);

  logic [IQ_DEPTH-1:0]     valid_q;
  logic [IQ_DEPTH-1:0]     spec_q;
  logic [IQ_DEPTH-1:0]     valid_nxt;
  logic [IQ_DEPTH-1:0]     spec_nxt;
  logic [IQ_DEPTH-1:0]     kill;
  logic [IQ_DEPTH-1:0]     jump_vec;
  iq_inst_t [IQ_DEPTH-1:0] mem_q;
  iq_slot_t                head_q;
  logic                    head_adv;

  assign head     = head_q;
  assign entries  = mem_q;
  assign occupied = {1'b0, iq_slot_t'(tail - head_q)};

  // ------------------------------------------------
  // flush and selection view
  // ------------------------------------------------

  // taken branch kills everything behind it this cycle
  assign kill = (br_resolved && br_taken) ? spec_q : '0;
  assign live = valid_q & ~kill;

  // ------------------------------------------------
  // next state of valid and spec
  // ------------------------------------------------

  // order is flush, dequeue, enqueue
  always_comb begin
    valid_nxt = valid_q & ~kill;
    spec_nxt  = br_resolved ? '0 : spec_q;

    if (issue_fire) begin
      valid_nxt[issue_slot0] = 1'b0;
      valid_nxt[issue_slot1] = 1'b0;
      spec_nxt[issue_slot0]  = 1'b0;
      spec_nxt[issue_slot1]  = 1'b0;
    end

    // new entries keep the spec flag their lane carried
    if (wr_en0) begin
      valid_nxt[wr_slot0] = 1'b1;
      spec_nxt[wr_slot0]  = wr_lane0.spec;
    end
    if (wr_en1) begin
      valid_nxt[wr_slot1] = 1'b1;
      spec_nxt[wr_slot1]  = wr_lane1.spec;
    end
  end

  // step over one freed slot per cycle
  assign head_adv = !valid_nxt[head_q] && (head_q != tail);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      spec_q  <= '0;
      head_q  <= '0;
    end else begin
      valid_q <= valid_nxt;
      spec_q  <= spec_nxt;
      if (head_adv) begin
        head_q <= head_q + iq_slot_t'(1);
      end
    end
  end

  // ------------------------------------------------
  // payload
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en0) begin
      mem_q[wr_slot0] <= wr_lane0.inst;
    end
    if (wr_en1) begin
      mem_q[wr_slot1] <= wr_lane1.inst;
    end
  end

  // jump indication straight from stored entries
  for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_jump
    assign jump_vec[i] = valid_q[i] && mem_q[i].jump;
  end

  assign contains_jump = |jump_vec;

endmodule

//--- iq_issue_select.sv
// ------------------------------------------------
// oldest eligible adjacent pair search from the
// head, issue handshake
// ------------------------------------------------

`timescale 1ns/1ns

module iq_issue_select import iq_pkg::*; (
  input  logic [IQ_DEPTH-1:0]     live,
  input  iq_inst_t [IQ_DEPTH-1:0] entries,
  input  iq_slot_t                head,
  input  logic [ROB_DEPTH-1:0]    src_ready,
  input  logic                    issue_rdy,

  output iq_issue_t               issue,
  output logic                    issue_val,
  output logic                    issue_fire
);

  logic [IQ_DEPTH-1:0] eligible;
  iq_slot_t            sel0;
  iq_slot_t            sel1;
  iq_slot_t            probe0;
  iq_slot_t            probe1;
  logic                found;

  // ------------------------------------------------
  // eligibility
  // ------------------------------------------------

  // live already drops entries killed by a taken branch
  for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_elig
    assign eligible[i] = live[i] && src_ready[entries[i].rob_slot];
  end

  // ------------------------------------------------
  // pair search
  // ------------------------------------------------

  // first hit from the head wins, pointer math wraps at depth
  always_comb begin
    found  = 1'b0;
    sel0   = head;
    sel1   = head + iq_slot_t'(1);
    probe0 = head;
    probe1 = head + iq_slot_t'(1);
    for (int off = 0; off < IQ_DEPTH - 1; off++) begin
      probe0 = head + iq_slot_t'(off);
      probe1 = probe0 + iq_slot_t'(1);
      if (!found && eligible[probe0] && eligible[probe1]) begin
        found = 1'b1;
        sel0  = probe0;
        sel1  = probe1;
      end
    end
  end

  assign issue.slot0 = sel0;
  assign issue.slot1 = sel1;
  assign issue.inst0 = entries[sel0];
  assign issue.inst1 = entries[sel1];

  assign issue_val  = found;
  assign issue_fire = found && issue_rdy;

endmodule

//--- issue_queue.sv
// ------------------------------------------------
// two-wide issue queue top level
// ------------------------------------------------

`timescale 1ns/1ns

module issue_queue import iq_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,

  input  iq_lane_t             lane0,
  input  iq_lane_t             lane1,
  output logic                 enq_rdy,

  output iq_issue_t            issue,
  output logic                 issue_val,
  input  logic                 issue_rdy,

  input  logic [ROB_DEPTH-1:0] src_ready,
  input  logic                 br_resolved,
  input  logic                 br_taken,
  output logic                 contains_jump
);

  logic                    wr_en0;
  logic                    wr_en1;
  iq_slot_t                wr_slot0;
  iq_slot_t                wr_slot1;
  iq_lane_t                wr_lane0;
  iq_lane_t                wr_lane1;
  iq_slot_t                tail;
  iq_slot_t                head;
  logic [IQ_PTR_W:0]       occupied;
  logic [IQ_DEPTH-1:0]     live;
  iq_inst_t [IQ_DEPTH-1:0] entries;
  logic                    issue_fire;

  iq_dispatch dispatch0 (
    .clk      (clk),
    .reset    (reset),
    .lane0    (lane0),
    .lane1    (lane1),
    .enq_rdy  (enq_rdy),
    .head     (head),
    .occupied (occupied),
    .tail     (tail),
    .wr_en0   (wr_en0),
    .wr_en1   (wr_en1),
    .wr_slot0 (wr_slot0),
    .wr_slot1 (wr_slot1),
    .wr_lane0 (wr_lane0),
    .wr_lane1 (wr_lane1)
  );

  iq_entry_buffer buffer0 (
    .clk           (clk),
    .reset         (reset),
    .wr_en0        (wr_en0),
    .wr_en1        (wr_en1),
    .wr_slot0      (wr_slot0),
    .wr_slot1      (wr_slot1),
    .wr_lane0      (wr_lane0),
    .wr_lane1      (wr_lane1),
    .tail          (tail),
    .issue_fire    (issue_fire),
    .issue_slot0   (issue.slot0),
    .issue_slot1   (issue.slot1),
    .br_resolved   (br_resolved),
    .br_taken      (br_taken),
    .head          (head),
    .occupied      (occupied),
    .live          (live),
    .entries       (entries),
    .contains_jump (contains_jump)
  );

  iq_issue_select select0 (
    .live       (live),
    .entries    (entries),
    .head       (head),
    .src_ready  (src_ready),
    .issue_rdy  (issue_rdy),
    .issue      (issue),
    .issue_val  (issue_val),
    .issue_fire (issue_fire)
  );

endmodule

//--- tb_iq_model.svh
// ------------------------------------------------
// issue queue reference model, pair selection
// reference and galois lfsr
// ------------------------------------------------

iq_inst_t    m_inst [IQ_DEPTH];
logic        m_valid [IQ_DEPTH];
logic        m_spec [IQ_DEPTH];
int          m_head;
int          m_tail;
logic [15:0] lfsr = 16'd52269;

// one lfsr step per bit, msb taken first
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    r = {r[30:0], lfsr[0]};
  end
  return r;
endfunction

function automatic int count_entries();
  return (m_tail - m_head + IQ_DEPTH) % IQ_DEPTH;
endfunction

// a pair needs two slots on top of the one kept open
function automatic logic expect_enq_rdy();
  return count_entries() <= IQ_DEPTH - 3;
endfunction

function automatic logic any_jump();
  logic j;
  j = 1'b0;
  for (int i = 0; i < IQ_DEPTH; i++) begin
    j = j | (m_valid[i] && m_inst[i].jump);
  end
  return j;
endfunction

// oldest adjacent pair of eligible entries, searched from the head
function automatic logic pick_pair(input logic [ROB_DEPTH-1:0] rdy, input logic kill,
                                   output iq_issue_t pick);
  int   p0;
  int   p1;
  logic e0;
  logic e1;
  pick = '0;
  for (int off = 0; off < IQ_DEPTH - 1; off++) begin
    p0 = (m_head + off) % IQ_DEPTH;
    p1 = (p0 + 1) % IQ_DEPTH;
    e0 = m_valid[p0] && !(kill && m_spec[p0]) && rdy[m_inst[p0].rob_slot];
    e1 = m_valid[p1] && !(kill && m_spec[p1]) && rdy[m_inst[p1].rob_slot];
    if (e0 && e1) begin
      pick = {iq_slot_t'(p0), iq_slot_t'(p1), m_inst[p0], m_inst[p1]};
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

task automatic reset_model();
  for (int i = 0; i < IQ_DEPTH; i++) begin
    m_valid[i] = 1'b0;
    m_spec[i]  = 1'b0;
  end
  m_head = 0;
  m_tail = 0;
endtask

task automatic write_entry(input iq_lane_t l);
  m_inst[m_tail]  = l.inst;
  m_valid[m_tail] = 1'b1;
  m_spec[m_tail]  = l.spec;
  m_tail = (m_tail + 1) % IQ_DEPTH;
endtask

// one clock edge: flush, dequeue, enqueue, head advance
task automatic step_model(input iq_lane_t l0, input iq_lane_t l1, input logic fire,
                          input iq_issue_t pick, input logic br_r, input logic br_t);
  logic enq;
  int   old_tail;
  enq = expect_enq_rdy();
  old_tail = m_tail;
  for (int i = 0; i < IQ_DEPTH; i++) begin
    if (br_r) begin
      if (br_t && m_spec[i]) m_valid[i] = 1'b0;
      m_spec[i] = 1'b0;
    end
  end
  if (fire) begin
    m_valid[pick.slot0] = 1'b0;
    m_valid[pick.slot1] = 1'b0;
  end
  if (enq && l0.val) write_entry(l0);
  if (enq && l1.val) write_entry(l1);
  if (!m_valid[m_head] && m_head != old_tail) m_head = (m_head + 1) % IQ_DEPTH;
endtask

//--- tb_issue_queue.sv
// ------------------------------------------------
// issue queue testbench with stimulus, compare
// process and compare tasks
// ------------------------------------------------

`timescale 1ns/1ns

module tb_issue_queue import iq_pkg::*; ();

  typedef logic [IQ_PTR_W:0] iq_count_t;

  logic                 clk;
  logic                 reset;
  iq_lane_t             lane0;
  iq_lane_t             lane1;
  logic                 enq_rdy;
  iq_issue_t            issue;
  logic                 issue_val;
  logic                 issue_rdy;
  logic [ROB_DEPTH-1:0] src_ready;
  logic                 br_resolved;
  logic                 br_taken;
  logic                 contains_jump;
  int                   pairs_issued = 0;

  `include "tb_iq_model.svh"

  issue_queue dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, act, exp));
  endtask

  task automatic check_issue(input string name, input iq_issue_t act, input iq_issue_t exp);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, act, exp));
  endtask

  task automatic check_count(input string name, input iq_count_t act, input iq_count_t exp);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, name, act, exp));
  endtask

  function automatic iq_lane_t make_lane(input logic val, input logic spec, input logic jump);
    iq_lane_t l;
    l.val = val;
    l.spec = spec;
    l.inst.ir = rand_bits(32);
    l.inst.rf_wen = rand_bits(1) != 0;
    l.inst.rf_waddr = REG_ADDR_W'(rand_bits(5));
    l.inst.alu_fn = alu_fn_e'(rand_bits(4) % 32'd11);
    l.inst.jump = jump;
    l.inst.rob_slot = ROB_SLOT_W'(rand_bits(5));
    l.inst.rs0_addr = REG_ADDR_W'(rand_bits(5));
    l.inst.rs1_addr = REG_ADDR_W'(rand_bits(5));
    return l;
  endfunction

  task automatic drive(input iq_lane_t l0, input iq_lane_t l1, input logic [ROB_DEPTH-1:0] rdy,
                       input logic irdy, input logic brr, input logic brt);
    @(posedge clk);
    lane0 <= l0;
    lane1 <= l1;
    src_ready <= rdy;
    issue_rdy <= irdy;
    br_resolved <= brr;
    br_taken <= brt;
  endtask

  task automatic apply_reset();
    drive('0, '0, '0, 1'b0, 1'b0, 1'b0);
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_issue(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!issue_val) begin
      n++;
      if (n > limit) abort_run("timed out waiting for issue_val");
      @(negedge clk);
    end
  endtask

  // model follows every edge, outputs sampled mid-cycle
  initial begin
    iq_issue_t exp;
    logic      found;
    forever begin
      @(negedge clk);
      if (reset) begin
        reset_model();
      end else begin
        found = pick_pair(src_ready, br_resolved && br_taken, exp);
        check_bit("issue_val", issue_val, found);
        if (found) check_issue("issue", issue, exp);
        check_bit("enq_rdy", enq_rdy, expect_enq_rdy());
        check_bit("contains_jump", contains_jump, any_jump());
        check_count("occupied", dut0.occupied, iq_count_t'(count_entries()));
        if (found && issue_rdy) pairs_issued++;
        step_model(lane0, lane1, found && issue_rdy, exp, br_resolved, br_taken);
      end
    end
  end

  initial begin
    repeat (6000) @(posedge clk);
    abort_run("simulation ran past its cycle limit");
  end

  initial begin
    iq_lane_t a;
    iq_lane_t b;
    iq_lane_t c;
    iq_lane_t d;
    int       n;
    reset <= 1'b1;
    lane0 <= '0;
    lane1 <= '0;
    src_ready <= '0;
    issue_rdy <= 1'b0;
    br_resolved <= 1'b0;
    br_taken <= 1'b0;
    apply_reset();

    // first pair issues the cycle after it is taken
    a = make_lane(1'b1, 1'b0, 1'b0);
    b = make_lane(1'b1, 1'b0, 1'b0);
    drive(a, b, '1, 1'b1, 1'b0, 1'b0);
    drive('0, '0, '1, 1'b1, 1'b0, 1'b0);
    @(negedge clk);
    check_bit("issue_val", issue_val, 1'b1);
    check_issue("issue", issue, {iq_slot_t'(0), iq_slot_t'(1), a.inst, b.inst});

    // ------------------------------------------------
    // fill with issue stalled
    // ------------------------------------------------
    apply_reset();
    n = 0;
    do begin
      drive(make_lane(1'b1, 1'b0, rand_bits(3) == 0), make_lane(1'b1, 1'b0, 1'b0),
            rand_bits(32), 1'b0, 1'b0, 1'b0);
      @(negedge clk);
      n++;
      if (n > 40) abort_run("enq_rdy never dropped while the queue was filling");
    end while (enq_rdy);
    repeat (8) drive(make_lane(1'b1, 1'b0, 1'b1), make_lane(1'b1, 1'b0, 1'b0),
                     rand_bits(32), 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check_count("occupied", dut0.occupied, iq_count_t'(30));

    // ------------------------------------------------
    // random traffic
    // ------------------------------------------------
    for (int r = 0; r < 6; r++) begin
      apply_reset();
      repeat (300) begin
        drive(make_lane(rand_bits(2) != 0, rand_bits(2) == 0, rand_bits(3) == 0),
              make_lane(rand_bits(2) != 0, rand_bits(2) == 0, rand_bits(3) == 0),
              rand_bits(32), rand_bits(2) != 0, rand_bits(4) == 0, rand_bits(1) != 0);
      end
    end

    // ------------------------------------------------
    // branch resolves
    // ------------------------------------------------
    apply_reset();
    a = make_lane(1'b1, 1'b1, 1'b0);
    b = make_lane(1'b1, 1'b1, 1'b0);
    c = make_lane(1'b1, 1'b0, 1'b1);
    d = make_lane(1'b1, 1'b0, 1'b0);
    drive(a, b, '0, 1'b1, 1'b0, 1'b0);
    drive(c, d, '0, 1'b1, 1'b0, 1'b0);
    drive('0, '0, '0, 1'b1, 1'b1, 1'b1);
    drive('0, '0, '1, 1'b1, 1'b0, 1'b0);
    wait_issue(4);
    check_issue("issue", issue, {iq_slot_t'(2), iq_slot_t'(3), c.inst, d.inst});
    // not-taken clears the mark, so the later taken resolve keeps them
    a = make_lane(1'b1, 1'b1, 1'b0);
    b = make_lane(1'b1, 1'b1, 1'b1);
    drive(a, b, '0, 1'b1, 1'b0, 1'b0);
    drive('0, '0, '0, 1'b1, 1'b1, 1'b0);
    drive('0, '0, '0, 1'b1, 1'b1, 1'b1);
    drive('0, '0, '1, 1'b1, 1'b0, 1'b0);
    wait_issue(4);
    check_issue("issue", issue, {iq_slot_t'(4), iq_slot_t'(5), a.inst, b.inst});
    repeat (4) drive('0, '0, '1, 1'b1, 1'b0, 1'b0);

    @(negedge clk);
    if (pairs_issued > 50) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run($sformatf("run ended with only %0d issued pairs", pairs_issued));
    end
  end

endmodule

//--- filelist.f
+incdir+.
iq_pkg.sv
iq_dispatch.sv
iq_entry_buffer.sv
iq_issue_select.sv
issue_queue.sv
tb_issue_queue.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_queue
RTL_TOP   ?= issue_queue
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
RTL_SRCS  ?= iq_pkg.sv iq_dispatch.sv iq_entry_buffer.sv iq_issue_select.sv issue_queue.sv

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
